/* design/video_pkg.sv */
package video_pkg;

    localparam int PIXEL_W             = 24;
    localparam int WORD_W              = 32;
    localparam int FRAME_WORDS         = 64;
    localparam int ADDR_W              = 6;
    localparam int BURST_LEN           = 8;
    localparam int LEN_W               = 4;
    localparam int FIFO_DEPTH          = 16;
    localparam int DESC_DEPTH          = 4;
    localparam int RESET_COUNT_DEFAULT = 16;

    typedef logic [PIXEL_W-1:0] pixel_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  mem_addr_t;
    typedef logic [LEN_W-1:0]   burst_len_t;

    // Counts 0 up to FRAME_WORDS inclusive
    typedef logic [ADDR_W:0]    word_count_t;

    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync_n;
        pixel_t pixel;
    } video_t;

    typedef struct packed {
        mem_addr_t  addr;
        burst_len_t len;
    } burst_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        word_t     data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_FRAME,
        CAPTURE,
        FLUSH
    } pack_state_e;

endpackage

/* design/apb_regs_pkg.sv */
package apb_regs_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CTRL    = 8'h00,
        REG_STATUS  = 8'h04,
        REG_RD_ADDR = 8'h08,
        REG_RD_DATA = 8'h0C
    } reg_addr_e;

    // Status register fields
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;
    localparam int STAT_COUNT_LSB = 8;

    // Control register fields
    localparam int CTRL_ARM_BIT   = 0;

endpackage

/* design/reset_counter.sv */
module reset_counter #(
    parameter int unsigned RESET_COUNT = video_pkg::RESET_COUNT_DEFAULT
) (
    input  logic clk_i,
    input  logic arst_n_i,
    output logic rst_o
);

    typedef logic [$clog2(RESET_COUNT + 1)-1:0] count_t;

    count_t count;

    // Assert at once, release on the clock after RESET_COUNT edges
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count <= '0;
            rst_o <= 1'b1;
        end else if (rst_o) begin
            if (count == count_t'(RESET_COUNT - 1)) begin
                rst_o <= 1'b0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* design/pixel_packer.sv */
module pixel_packer (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  video_pkg::video_t      video_i,
    input  logic                   arm_i,
    output video_pkg::word_t       word_o,
    output logic                   word_push_o,
    output video_pkg::burst_t      burst_o,
    output logic                   burst_push_o,
    output logic                   frame_done_o,
    output video_pkg::word_count_t word_count_o
);

    import video_pkg::*;

    pack_state_e state;
    logic        vsync_q;
    logic        vsync_fall;
    logic        accept;
    logic        burst_due;
    word_count_t word_cnt;
    burst_len_t  burst_cnt;
    mem_addr_t   burst_base;

    assign vsync_fall = vsync_q && !video_i.vsync_n;

    // Store full means no more pixels for this capture
    assign accept = (state == CAPTURE) && video_i.de && !vsync_fall &&
                    (word_cnt < word_count_t'(FRAME_WORDS));

    // Full burst, or whatever is left once capture stops
    assign burst_due = (burst_cnt == burst_len_t'(BURST_LEN)) ||
                       ((state == FLUSH) && (burst_cnt != '0));

    assign burst_base = word_cnt[ADDR_W-1:0] - mem_addr_t'(burst_cnt);

    assign word_count_o = word_cnt;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state        <= IDLE;
            vsync_q      <= 1'b1;
            word_cnt     <= '0;
            burst_cnt    <= '0;
            word_push_o  <= 1'b0;
            burst_push_o <= 1'b0;
            frame_done_o <= 1'b0;
        end else begin
            vsync_q      <= video_i.vsync_n;
            word_push_o  <= accept;
            burst_push_o <= burst_due;
            frame_done_o <= (state == FLUSH);

            if (accept) begin
                word_cnt <= word_cnt + 1'b1;
            end

            // A pixel arriving with the descriptor opens the next burst
            if (burst_due) begin
                burst_cnt <= burst_len_t'(accept);
            end else if (accept) begin
                burst_cnt <= burst_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (arm_i) begin
                        state     <= WAIT_FRAME;
                        word_cnt  <= '0;
                        burst_cnt <= '0;
                    end
                end
                WAIT_FRAME: begin
                    if (vsync_fall) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (vsync_fall || (word_cnt == word_count_t'(FRAME_WORDS))) begin
                        state <= FLUSH;
                    end
                end
                FLUSH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            word_o <= word_t'(video_i.pixel);
        end
        if (burst_due) begin
            burst_o <= '{addr: burst_base, len: burst_cnt};
        end
    end

endmodule

/* design/burst_writer.sv */
module burst_writer (
    input  logic               clk_i,
    input  logic               rst_i,
    input  video_pkg::word_t   word_i,
    input  logic               word_push_i,
    input  video_pkg::burst_t  burst_i,
    input  logic               burst_push_i,
    output video_pkg::mem_wr_t mem_wr_o,
    output logic               idle_o
);

    import video_pkg::*;

    word_t                           word_mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   word_wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   word_rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]     word_fill;

    burst_t                          desc_mem [DESC_DEPTH];
    logic [$clog2(DESC_DEPTH)-1:0]   desc_wr_ptr;
    logic [$clog2(DESC_DEPTH)-1:0]   desc_rd_ptr;
    logic [$clog2(DESC_DEPTH):0]     desc_fill;

    burst_t     desc_head;
    burst_len_t remain;
    mem_addr_t  wr_addr;
    logic       start;
    logic       word_pop;
    logic       wr_en;
    mem_addr_t  wr_addr_q;
    word_t      wr_data_q;

    assign desc_head = desc_mem[desc_rd_ptr];

    // Next burst may follow the last word of the previous one directly
    assign start    = (remain == '0) && (desc_fill != '0) && (word_fill >= desc_head.len);
    assign word_pop = start || (remain != '0);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            word_wr_ptr <= '0;
            word_rd_ptr <= '0;
            word_fill   <= '0;
            desc_wr_ptr <= '0;
            desc_rd_ptr <= '0;
            desc_fill   <= '0;
            remain      <= '0;
            wr_addr     <= '0;
            wr_en       <= 1'b0;
        end else begin
            if (word_push_i) begin
                word_wr_ptr <= word_wr_ptr + 1'b1;
            end
            if (word_pop) begin
                word_rd_ptr <= word_rd_ptr + 1'b1;
            end
            word_fill <= word_fill + word_push_i - word_pop;

            if (burst_push_i) begin
                desc_wr_ptr <= desc_wr_ptr + 1'b1;
            end
            if (start) begin
                desc_rd_ptr <= desc_rd_ptr + 1'b1;
            end
            desc_fill <= desc_fill + burst_push_i - start;

            // First word goes out in the start cycle
            if (start) begin
                remain  <= desc_head.len - 1'b1;
                wr_addr <= desc_head.addr + 1'b1;
            end else if (remain != '0) begin
                remain  <= remain - 1'b1;
                wr_addr <= wr_addr + 1'b1;
            end

            wr_en <= word_pop;
        end
    end

    always_ff @(posedge clk_i) begin
        if (word_push_i) begin
            word_mem[word_wr_ptr] <= word_i;
        end
        if (burst_push_i) begin
            desc_mem[desc_wr_ptr] <= burst_i;
        end
        if (word_pop) begin
            wr_data_q <= word_mem[word_rd_ptr];
            wr_addr_q <= start ? desc_head.addr : wr_addr;
        end
    end

    assign mem_wr_o = '{en: wr_en, addr: wr_addr_q, data: wr_data_q};

    // Idle only once the last write has left the output register
    assign idle_o = (word_fill == '0) && (desc_fill == '0) && (remain == '0) && !wr_en;

endmodule

/* design/frame_store.sv */
module frame_store (
    input  logic                 clk_i,
    input  video_pkg::mem_wr_t   mem_wr_i,
    input  video_pkg::mem_addr_t rd_addr_i,
    output video_pkg::word_t     rd_data_o
);

    import video_pkg::*;

    word_t mem [FRAME_WORDS];

    always_ff @(posedge clk_i) begin
        if (mem_wr_i.en) begin
            mem[mem_wr_i.addr] <= mem_wr_i.data;
        end
    end

    // Read data follows the address by one cycle
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

/* design/capture_regs.sv */
module capture_regs (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  apb_regs_pkg::apb_req_t apb_i,
    output apb_regs_pkg::apb_rsp_t apb_o,
    output logic                   arm_o,
    input  logic                   frame_done_i,
    input  logic                   writer_idle_i,
    input  video_pkg::word_count_t word_count_i,
    output video_pkg::mem_addr_t   rd_addr_o,
    input  video_pkg::word_t       rd_data_i
);

    import video_pkg::*;
    import apb_regs_pkg::*;

    logic                  setup;
    logic                  wait_access;
    logic                  addr_ok;
    logic                  arm_req;
    logic                  rd_data_rd;
    logic                  err;
    logic                  busy;
    logic                  done;
    logic                  done_seen;
    logic                  pready_q;
    logic                  pslverr_q;
    logic [APB_DATA_W-1:0] prdata_q;
    logic [APB_DATA_W-1:0] rdata;
    mem_addr_t             rd_ptr;

    assign setup       = apb_i.psel && !apb_i.penable;
    assign wait_access = apb_i.psel && apb_i.penable && !pready_q;

    always_comb begin
        addr_ok = 1'b1;
        rdata   = '0;
        case (reg_addr_e'(apb_i.paddr))
            REG_CTRL: rdata[CTRL_ARM_BIT] = busy;
            REG_STATUS: begin
                rdata[STAT_BUSY_BIT] = busy;
                rdata[STAT_DONE_BIT] = done;
                rdata[STAT_COUNT_LSB +: $bits(word_count_t)] = word_count_i;
            end
            REG_RD_ADDR: rdata[ADDR_W-1:0] = rd_ptr;
            REG_RD_DATA: rdata = rd_data_i;
            default: addr_ok = 1'b0;
        endcase
    end

    assign arm_req    = apb_i.pwrite && (apb_i.paddr == REG_CTRL) && apb_i.pwdata[CTRL_ARM_BIT];
    assign rd_data_rd = !apb_i.pwrite && (apb_i.paddr == REG_RD_DATA);
    assign err        = !addr_ok || (arm_req && busy);

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pready_q  <= 1'b0;
            pslverr_q <= 1'b0;
            arm_o     <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            done_seen <= 1'b0;
            rd_ptr    <= '0;
        end else begin
            arm_o <= 1'b0;

            // Capture ends when the packer is finished and the store is written
            if (frame_done_i) begin
                done_seen <= 1'b1;
            end
            if (busy && done_seen && writer_idle_i) begin
                busy      <= 1'b0;
                done      <= 1'b1;
                done_seen <= 1'b0;
            end

            if (pready_q) begin
                pready_q  <= 1'b0;
                pslverr_q <= 1'b0;
            end else if (setup) begin
                // Readback needs one more cycle for the store
                pready_q  <= !rd_data_rd || err;
                pslverr_q <= err;
                if (apb_i.pwrite && !err) begin
                    if (arm_req) begin
                        arm_o     <= 1'b1;
                        busy      <= 1'b1;
                        done      <= 1'b0;
                        done_seen <= 1'b0;
                    end
                    if (apb_i.paddr == REG_RD_ADDR) begin
                        rd_ptr <= apb_i.pwdata[ADDR_W-1:0];
                    end
                end
            end else if (wait_access) begin
                pready_q <= 1'b1;
                rd_ptr   <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (setup || wait_access) begin
            prdata_q <= rdata;
        end
    end

    assign rd_addr_o = rd_ptr;
    assign apb_o     = '{prdata: prdata_q, pready: pready_q, pslverr: pslverr_q};

endmodule

/* design/grabber_top.sv */
module grabber_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  video_pkg::video_t      video_i,
    input  apb_regs_pkg::apb_req_t apb_i,
    output apb_regs_pkg::apb_rsp_t apb_o
);

    import video_pkg::*;

    logic        rst;
    logic        arm;
    word_t       word;
    logic        word_push;
    burst_t      burst;
    logic        burst_push;
    logic        frame_done;
    word_count_t word_count;
    mem_wr_t     mem_wr;
    logic        writer_idle;
    mem_addr_t   rd_addr;
    word_t       rd_data;

    reset_counter #(
        .RESET_COUNT(RESET_COUNT_DEFAULT)
    ) u_reset_counter (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .rst_o   (rst)
    );

    pixel_packer u_pixel_packer (
        .clk_i       (clk_i),
        .rst_i       (rst),
        .video_i     (video_i),
        .arm_i       (arm),
        .word_o      (word),
        .word_push_o (word_push),
        .burst_o     (burst),
        .burst_push_o(burst_push),
        .frame_done_o(frame_done),
        .word_count_o(word_count)
    );

    burst_writer u_burst_writer (
        .clk_i       (clk_i),
        .rst_i       (rst),
        .word_i      (word),
        .word_push_i (word_push),
        .burst_i     (burst),
        .burst_push_i(burst_push),
        .mem_wr_o    (mem_wr),
        .idle_o      (writer_idle)
    );

    frame_store u_frame_store (
        .clk_i    (clk_i),
        .mem_wr_i (mem_wr),
        .rd_addr_i(rd_addr),
        .rd_data_o(rd_data)
    );

    capture_regs u_capture_regs (
        .clk_i        (clk_i),
        .rst_i        (rst),
        .apb_i        (apb_i),
        .apb_o        (apb_o),
        .arm_o        (arm),
        .frame_done_i (frame_done),
        .writer_idle_i(writer_idle),
        .word_count_i (word_count),
        .rd_addr_o    (rd_addr),
        .rd_data_i    (rd_data)
    );

endmodule

/* bench/tb_video_source.sv */
module tb_video_source (
    input  logic              clk_i,
    input  logic [31:0]       rnd_i,
    output video_pkg::video_t video_o
);

    import video_pkg::*;

    localparam int VSYNC_CYCLES  = 4;
    localparam int PORCH_CYCLES  = 2;
    localparam int LINE_CYCLES   = 12;
    localparam int HBLANK_CYCLES = 3;

    // Words the DUT should store for the armed capture
    word_t expected [$];
    int    active_pixels;
    logic  armed;
    logic  capturing;

    initial begin
        video_o       = '{de: 1'b0, hsync: 1'b0, vsync_n: 1'b1, pixel: '0};
        active_pixels = 0;
        armed         = 1'b0;
        capturing     = 1'b0;
    end

    task automatic expect_capture();
        expected.delete();
        armed = 1'b1;
    endtask

    // One video cycle, driven just after the rising edge
    task automatic drive(input logic active, input logic hsync, input logic vsync_n);
        logic   de;
        pixel_t pixel;
        @(posedge clk_i);
        #2;
        de    = active && (rnd_i[2:0] != 3'd0);
        pixel = active ? rnd_i[31:8] : '0;
        // Capture runs from one vsync fall to the next
        if (video_o.vsync_n && !vsync_n) begin
            if (capturing) begin
                capturing = 1'b0;
            end else if (armed) begin
                capturing = 1'b1;
                armed     = 1'b0;
            end
            active_pixels = 0;
        end
        if (de) begin
            active_pixels++;
            if (capturing && (expected.size() < FRAME_WORDS)) begin
                expected.push_back(word_t'(pixel));
            end
        end
        video_o = '{de: de, hsync: hsync, vsync_n: vsync_n, pixel: pixel};
    endtask

    task automatic send_vsync();
        repeat (VSYNC_CYCLES) begin
            drive(1'b0, 1'b0, 1'b0);
        end
        repeat (PORCH_CYCLES) begin
            drive(1'b0, 1'b0, 1'b1);
        end
    endtask

    task automatic send_frame(input int lines);
        send_vsync();
        repeat (lines) begin
            repeat (LINE_CYCLES) begin
                drive(1'b1, 1'b0, 1'b1);
            end
            repeat (HBLANK_CYCLES) begin
                drive(1'b0, 1'b1, 1'b1);
            end
        end
    endtask

endmodule

/* bench/tb_grabber.sv */
module tb_grabber;

    import video_pkg::*;
    import apb_regs_pkg::*;

    localparam int          CLK_HALF      = 10;
    localparam int          DRIVE_DELAY   = 2;
    localparam int          READY_TIMEOUT = 16;
    localparam int          DONE_POLLS    = 64;
    localparam int          RUN_CYCLES    = 20000;
    localparam logic [31:0] SEED          = 32'h33d3_e3b5;
    localparam logic [31:0] ARM_WORD      = 32'd1 << CTRL_ARM_BIT;

    logic        clk;
    logic        arst_n;
    video_t      video;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [31:0] rnd;
    word_t       mem_model [FRAME_WORDS];

    grabber_top dut (
        .clk_i   (clk),
        .arst_n_i(arst_n),
        .video_i (video),
        .apb_i   (apb_req),
        .apb_o   (apb_rsp)
    );

    tb_video_source src (
        .clk_i  (clk),
        .rnd_i  (rnd),
        .video_o(video)
    );

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always @(posedge clk) begin
        rnd <= xorshift(rnd);
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int waited;
        int exp_waits;
        // Only a readback of the store adds a wait state
        exp_waits = (!write && (addr == REG_RD_DATA)) ? 1 : 0;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req.penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin
            if (waited == READY_TIMEOUT) begin
                $display("Timeout: pready never rose for the access to address %h", addr);
                abort_run();
            end
            waited++;
            @(negedge clk);
        end
        check($sformatf("wait states for address %h", addr), exp_waits, waited);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, input string name);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, data, rdata, err);
        check({name, " pslverr"}, exp_err, err);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic exp_err, input string name,
                            output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check({name, " pslverr"}, exp_err, err);
    endtask

    task automatic wait_done(input string name);
        logic [31:0] status;
        int          polls;
        polls  = 0;
        status = '0;
        while (!status[STAT_DONE_BIT]) begin
            if (polls == DONE_POLLS) begin
                $display("Timeout: done bit never set during %s", name);
                abort_run();
            end
            read_reg(REG_STATUS, 1'b0, name, status);
            polls++;
        end
    endtask

    // Expected count in STATUS, then every word read back from address 0
    task automatic verify_capture(input string name);
        logic [31:0] data;
        int          n;
        n = src.expected.size();
        wait_done(name);
        read_reg(REG_STATUS, 1'b0, name, data);
        check({name, " status"}, (n << STAT_COUNT_LSB) | (1 << STAT_DONE_BIT), data);
        write_reg(REG_RD_ADDR, 32'd0, 1'b0, name);
        for (int i = 0; i < n; i++) begin
            read_reg(REG_RD_DATA, 1'b0, name, data);
            check($sformatf("%s word %0d", name, i), src.expected[i], data);
            mem_model[i] = src.expected[i];
        end
    endtask

    initial begin
        #(2 * CLK_HALF * RUN_CYCLES);
        $display("Timeout: simulation ran past its cycle limit");
        abort_run();
    end

    initial begin
        logic [31:0] data;
        logic [5:0]  addr;
        clk     = 1'b0;
        arst_n  = 1'b0;
        apb_req = '0;
        rnd     = SEED;
        repeat (3) begin
            @(posedge clk);
        end
        #DRIVE_DELAY;
        arst_n = 1'b1;
        // Setup phase held while the internal reset is still stretched
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: REG_STATUS, pwdata: '0};
        repeat (RESET_COUNT_DEFAULT - 2) begin
            @(negedge clk);
            check("pready during reset", 32'd0, apb_rsp.pready);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        apb_req = '0;
        repeat (4) begin
            @(negedge clk);
            check("pready during reset", 32'd0, apb_rsp.pready);
        end

        read_reg(REG_STATUS, 1'b0, "reset status", data);
        check("reset status", 32'd0, data);

        // Short frame
        write_reg(REG_CTRL, ARM_WORD, 1'b0, "short arm");
        src.expect_capture();
        read_reg(REG_STATUS, 1'b0, "armed status", data);
        check("armed status", 32'd1 << STAT_BUSY_BIT, data);
        src.send_frame(3);
        src.send_vsync();
        verify_capture("short frame");

        // Frame larger than the store
        write_reg(REG_CTRL, ARM_WORD, 1'b0, "long arm");
        src.expect_capture();
        src.send_frame(10);
        check("long frame has more pixels than store", 32'd1,
              src.active_pixels > FRAME_WORDS);
        src.send_vsync();
        check("long frame count", FRAME_WORDS, src.expected.size());
        verify_capture("long frame");

        // Arm in the middle of a frame
        fork
            src.send_frame(6);
            begin
                repeat (20) begin
                    @(posedge clk);
                end
                write_reg(REG_CTRL, ARM_WORD, 1'b0, "mid-frame arm");
                src.expect_capture();
            end
        join
        src.send_frame(3);
        src.send_vsync();
        verify_capture("next frame");

        // Rejected accesses while busy
        write_reg(REG_CTRL, ARM_WORD, 1'b0, "busy arm");
        src.expect_capture();
        read_reg(REG_STATUS, 1'b0, "busy status", data);
        check("busy status", 32'd1 << STAT_BUSY_BIT, data);
        write_reg(REG_CTRL, ARM_WORD, 1'b1, "arm while busy");
        read_reg(REG_STATUS, 1'b0, "busy status", data);
        check("status after rejected arm", 32'd1 << STAT_BUSY_BIT, data);
        read_reg(8'h10, 1'b1, "unmapped read", data);
        read_reg(REG_STATUS, 1'b0, "busy status", data);
        check("status after unmapped read", 32'd1 << STAT_BUSY_BIT, data);
        src.send_frame(2);
        src.send_vsync();
        verify_capture("busy frame");

        // Readback from a random pointer
        addr = rnd[5:0];
        write_reg(REG_RD_ADDR, {26'd0, addr}, 1'b0, "random pointer");
        read_reg(REG_RD_DATA, 1'b0, "random read", data);
        check("random word 0", mem_model[addr], data);
        read_reg(REG_RD_DATA, 1'b0, "random read", data);
        check("random word 1", mem_model[addr + 6'd1], data);
        read_reg(REG_RD_ADDR, 1'b0, "pointer readback", data);
        check("pointer readback", {26'd0, addr + 6'd2}, data);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* grabber.f */
design/video_pkg.sv
design/apb_regs_pkg.sv
design/reset_counter.sv
design/pixel_packer.sv
design/burst_writer.sv
design/frame_store.sv
design/capture_regs.sv
design/grabber_top.sv
bench/tb_video_source.sv
bench/tb_grabber.sv

/* Bender.yml */
package:
  name: grabber

sources:
  - design/video_pkg.sv
  - design/apb_regs_pkg.sv
  - design/reset_counter.sv
  - design/pixel_packer.sv
  - design/burst_writer.sv
  - design/frame_store.sv
  - design/capture_regs.sv
  - design/grabber_top.sv
  - target: test
    files:
      - bench/tb_video_source.sv
      - bench/tb_grabber.sv
